// File: hw/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// data word width
`define ID_XLEN 32

// register file geometry
`define ID_REG_AW 5
`define ID_NUM_REGS 32

`endif

// File: hw/id_pkg.sv
`default_nettype none

package id_pkg;

  `include "id_params.svh"

  typedef logic [`ID_XLEN-1:0] word_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_t;

  // direct covers b and bl
  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE,
    BR_LTU, BR_GEU, BR_JIRL, BR_DIRECT
  } br_kind_t;

  typedef struct packed {
    alu_op_t   alu_op;
    br_kind_t  br_kind;
    reg_addr_t dest;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      src2_is_4;
    logic      load;
    logic      store;
    logic      gr_we;
    logic      need_rj;
    logic      need_rkd;
    logic      src_reg_is_rd;
  } dec_ctrl_t;

endpackage

`default_nettype wire

// File: hw/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

// a later stage offering its result for forwarding
interface fwd_if import id_pkg::*; ();
  logic      stall;
  logic      en;
  reg_addr_t addr;
  word_t     data;

  modport source (output stall, en, addr, data);
  modport sink (input stall, en, addr, data);
endinterface

`default_nettype wire

// File: hw/id_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module id_slot_ctrl import id_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  fs_valid,
  input  word_t fs_pc,
  input  word_t fs_inst,
  input  logic  es_allowin,
  input  logic  stall,
  input  logic  br_taken,
  output logic  ds_allowin,
  output logic  ds_to_es_valid,
  output logic  slot_valid,
  output word_t ds_pc,
  output word_t ds_inst
);

  typedef enum logic {SLOT_EMPTY, SLOT_FULL} slot_state_t;

  slot_state_t state;

  assign slot_valid     = (state == SLOT_FULL);
  assign ds_allowin     = !slot_valid || (es_allowin && !stall);
  assign ds_to_es_valid = slot_valid && !stall;

  // a taken branch drops whatever would come in behind it
  always_ff @(posedge clk) begin
    if (rst || br_taken) begin
      state <= SLOT_EMPTY;
    end else if (ds_allowin) begin
      state <= fs_valid ? SLOT_FULL : SLOT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_valid && ds_allowin) begin
      ds_pc   <= fs_pc;
      ds_inst <= fs_inst;
    end
  end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
  input  word_t     inst,
  input  word_t     pc,
  output dec_ctrl_t ctrl,
  output word_t     imm,
  output reg_addr_t rj,
  output reg_addr_t rkd
);

  logic [5:0] op_31_26;
  logic [3:0] op_25_22;
  logic [1:0] op_21_20;
  logic [4:0] op_19_15;
  logic [4:0] rd;
  logic [4:0] rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;
  logic grp_3r, grp_2ri5;
  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
  logic inst_and, inst_or, inst_nor, inst_xor;
  logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic inst_slli_w, inst_srli_w, inst_srai_w, inst_lu12i_w, inst_pcaddu12i;
  logic inst_ld_w, inst_st_w;
  logic inst_jirl, inst_b, inst_bl;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic cond_br, alu_3r, alu_si12, alu_ui12, alu_ui5;

  assign op_31_26 = inst[31:26];
  assign op_25_22 = inst[25:22];
  assign op_21_20 = inst[21:20];
  assign op_19_15 = inst[19:15];
  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i16 = inst[25:10];
  assign i20 = inst[24:5];
  assign i26 = {inst[9:0], inst[25:10]};

  assign grp_3r   = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
  assign grp_2ri5 = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

  assign inst_add_w  = grp_3r && (op_19_15 == 5'h00);
  assign inst_sub_w  = grp_3r && (op_19_15 == 5'h02);
  assign inst_slt    = grp_3r && (op_19_15 == 5'h04);
  assign inst_sltu   = grp_3r && (op_19_15 == 5'h05);
  assign inst_nor    = grp_3r && (op_19_15 == 5'h08);
  assign inst_and    = grp_3r && (op_19_15 == 5'h09);
  assign inst_or     = grp_3r && (op_19_15 == 5'h0a);
  assign inst_xor    = grp_3r && (op_19_15 == 5'h0b);
  assign inst_slli_w = grp_2ri5 && (op_19_15 == 5'h01);
  assign inst_srli_w = grp_2ri5 && (op_19_15 == 5'h09);
  assign inst_srai_w = grp_2ri5 && (op_19_15 == 5'h11);

  assign inst_slti   = (op_31_26 == 6'h00) && (op_25_22 == 4'h8);
  assign inst_sltui  = (op_31_26 == 6'h00) && (op_25_22 == 4'h9);
  assign inst_addi_w = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
  assign inst_andi   = (op_31_26 == 6'h00) && (op_25_22 == 4'hd);
  assign inst_ori    = (op_31_26 == 6'h00) && (op_25_22 == 4'he);
  assign inst_xori   = (op_31_26 == 6'h00) && (op_25_22 == 4'hf);
  assign inst_ld_w   = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
  assign inst_st_w   = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);

  assign inst_lu12i_w   = (op_31_26 == 6'h05) && !inst[25];
  assign inst_pcaddu12i = (op_31_26 == 6'h07) && !inst[25];
  assign inst_jirl = (op_31_26 == 6'h13);
  assign inst_b    = (op_31_26 == 6'h14);
  assign inst_bl   = (op_31_26 == 6'h15);
  assign inst_beq  = (op_31_26 == 6'h16);
  assign inst_bne  = (op_31_26 == 6'h17);
  assign inst_blt  = (op_31_26 == 6'h18);
  assign inst_bge  = (op_31_26 == 6'h19);
  assign inst_bltu = (op_31_26 == 6'h1a);
  assign inst_bgeu = (op_31_26 == 6'h1b);

  assign cond_br  = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign alu_3r   = inst_add_w | inst_sub_w | inst_slt | inst_sltu |
                    inst_and | inst_or | inst_nor | inst_xor;
  assign alu_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
  assign alu_ui12 = inst_andi | inst_ori | inst_xori;
  assign alu_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;

  // second read port sees rd for branches and stores
  assign rkd = ctrl.src_reg_is_rd ? rd : rk;

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = ALU_ADD;
    if (inst_sub_w) ctrl.alu_op = ALU_SUB;
    else if (inst_slt || inst_slti) ctrl.alu_op = ALU_SLT;
    else if (inst_sltu || inst_sltui) ctrl.alu_op = ALU_SLTU;
    else if (inst_and || inst_andi) ctrl.alu_op = ALU_AND;
    else if (inst_nor) ctrl.alu_op = ALU_NOR;
    else if (inst_or || inst_ori) ctrl.alu_op = ALU_OR;
    else if (inst_xor || inst_xori) ctrl.alu_op = ALU_XOR;
    else if (inst_slli_w) ctrl.alu_op = ALU_SLL;
    else if (inst_srli_w) ctrl.alu_op = ALU_SRL;
    else if (inst_srai_w) ctrl.alu_op = ALU_SRA;
    else if (inst_lu12i_w) ctrl.alu_op = ALU_LUI;

    ctrl.br_kind = BR_NONE;
    if (inst_beq) ctrl.br_kind = BR_EQ;
    else if (inst_bne) ctrl.br_kind = BR_NE;
    else if (inst_blt) ctrl.br_kind = BR_LT;
    else if (inst_bge) ctrl.br_kind = BR_GE;
    else if (inst_bltu) ctrl.br_kind = BR_LTU;
    else if (inst_bgeu) ctrl.br_kind = BR_GEU;
    else if (inst_jirl) ctrl.br_kind = BR_JIRL;
    else if (inst_b || inst_bl) ctrl.br_kind = BR_DIRECT;

    ctrl.dest          = inst_bl ? 5'd1 : rd;
    ctrl.src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu12i;
    ctrl.src2_is_imm   = alu_si12 | alu_ui12 | alu_ui5 | inst_lu12i_w | inst_pcaddu12i;
    ctrl.src2_is_4     = inst_jirl | inst_bl;
    ctrl.load          = inst_ld_w;
    ctrl.store         = inst_st_w;
    ctrl.gr_we         = alu_3r | alu_ui12 | alu_ui5 | (alu_si12 & ~inst_st_w) |
                         inst_lu12i_w | inst_pcaddu12i | inst_jirl | inst_bl;
    ctrl.need_rj       = alu_3r | alu_si12 | alu_ui12 | alu_ui5 | cond_br | inst_jirl;
    ctrl.need_rkd      = alu_3r | cond_br | inst_st_w;
    ctrl.src_reg_is_rd = cond_br | inst_st_w;
  end

  always_comb begin
    imm = '0;
    if (alu_ui5) imm = {27'b0, rk};
    else if (alu_si12) imm = {{20{i12[11]}}, i12};
    else if (alu_ui12) imm = {20'b0, i12};
    else if (cond_br || inst_jirl) imm = {{14{i16[15]}}, i16, 2'b0};
    else if (inst_lu12i_w || inst_pcaddu12i) imm = {i20, 12'b0};
    else if (inst_b || inst_bl) imm = {{4{i26[25]}}, i26, 2'b0};
  end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"

module regfile import id_pkg::*; (
  input  logic      clk,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t rf [`ID_NUM_REGS];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      rf[waddr] <= wdata;
    end
  end

  // r0 is hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

// File: hw/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
  input  dec_ctrl_t ctrl,
  input  reg_addr_t rj,
  input  reg_addr_t rkd,
  input  word_t     rf_rdata1,
  input  word_t     rf_rdata2,
  fwd_if.sink       es,
  fwd_if.sink       ms,
  fwd_if.sink       wb,
  output word_t     rj_value,
  output word_t     rkd_value,
  output logic      stall
);

  typedef struct packed {
    logic  stall;
    word_t data;
  } pick_t;

  pick_t pick1, pick2;

  // nearest stage wins
  function automatic pick_t pick(input reg_addr_t ra, input logic need, input word_t rf_val);
    pick_t p;
    p.stall = 1'b0;
    p.data  = rf_val;
    if (need && (ra != '0)) begin
      if (es.en && (es.addr == ra)) begin
        p.stall = es.stall;
        p.data  = es.data;
      end else if (ms.en && (ms.addr == ra)) begin
        p.stall = ms.stall;
        p.data  = ms.data;
      end else if (wb.en && (wb.addr == ra)) begin
        p.stall = wb.stall;
        p.data  = wb.data;
      end
    end
    return p;
  endfunction

  always_comb begin
    pick1 = pick(rj, ctrl.need_rj, rf_rdata1);
    pick2 = pick(rkd, ctrl.need_rkd, rf_rdata2);
  end

  assign rj_value  = pick1.data;
  assign rkd_value = pick2.data;
  assign stall     = pick1.stall | pick2.stall;

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
  input  dec_ctrl_t ctrl,
  input  logic      slot_valid,
  input  word_t     pc,
  input  word_t     imm,
  input  word_t     rj_value,
  input  word_t     rkd_value,
  output logic      br_taken,
  output word_t     br_target
);

  logic eq, lt, ltu;
  logic cond;

  assign eq  = (rj_value == rkd_value);
  assign ltu = (rj_value < rkd_value);
  assign lt  = ($signed(rj_value) < $signed(rkd_value));

  always_comb begin
    case (ctrl.br_kind)
      BR_EQ:     cond = eq;
      BR_NE:     cond = !eq;
      BR_LT:     cond = lt;
      BR_GE:     cond = !lt;
      BR_LTU:    cond = ltu;
      BR_GEU:    cond = !ltu;
      BR_JIRL:   cond = 1'b1;
      BR_DIRECT: cond = 1'b1;
      default:   cond = 1'b0;
    endcase
  end

  assign br_taken  = slot_valid && cond;
  // jirl is register relative and the rest pc relative
  assign br_target = ((ctrl.br_kind == BR_JIRL) ? rj_value : pc) + imm;

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      fs_valid,
  input  word_t     fs_pc,
  input  word_t     fs_inst,
  input  logic      es_allowin,
  input  logic      es_fwd_stall,
  input  logic      es_fwd_en,
  input  reg_addr_t es_fwd_reg,
  input  word_t     es_fwd_data,
  input  logic      ms_fwd_stall,
  input  logic      ms_fwd_en,
  input  reg_addr_t ms_fwd_reg,
  input  word_t     ms_fwd_data,
  input  logic      wb_we,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output logic      ds_allowin,
  output logic      ds_to_es_valid,
  output word_t     ds_pc,
  output alu_op_t   alu_op,
  output logic      src1_is_pc,
  output logic      src2_is_imm,
  output logic      src2_is_4,
  output logic      load,
  output logic      store,
  output logic      gr_we,
  output reg_addr_t dest,
  output word_t     imm,
  output word_t     rj_value,
  output word_t     rkd_value,
  output logic      br_taken,
  output word_t     br_target
);

  dec_ctrl_t ctrl;
  word_t     ds_inst;
  reg_addr_t rj, rkd;
  word_t     rf_rdata1, rf_rdata2;
  logic      slot_valid;
  logic      stall;

  fwd_if es_fwd ();
  fwd_if ms_fwd ();
  fwd_if wb_fwd ();

  assign es_fwd.stall = es_fwd_stall;
  assign es_fwd.en    = es_fwd_en;
  assign es_fwd.addr  = es_fwd_reg;
  assign es_fwd.data  = es_fwd_data;
  assign ms_fwd.stall = ms_fwd_stall;
  assign ms_fwd.en    = ms_fwd_en;
  assign ms_fwd.addr  = ms_fwd_reg;
  assign ms_fwd.data  = ms_fwd_data;
  // write-back data is always final
  assign wb_fwd.stall = 1'b0;
  assign wb_fwd.en    = wb_we;
  assign wb_fwd.addr  = wb_addr;
  assign wb_fwd.data  = wb_data;

  id_slot_ctrl slot_inst (
    .clk(clk), .rst(rst),
    .fs_valid(fs_valid), .fs_pc(fs_pc), .fs_inst(fs_inst),
    .es_allowin(es_allowin), .stall(stall), .br_taken(br_taken),
    .ds_allowin(ds_allowin), .ds_to_es_valid(ds_to_es_valid),
    .slot_valid(slot_valid), .ds_pc(ds_pc), .ds_inst(ds_inst)
  );

  inst_decoder dec_inst (
    .inst(ds_inst), .pc(ds_pc), .ctrl(ctrl), .imm(imm), .rj(rj), .rkd(rkd)
  );

  regfile rf_inst (
    .clk(clk), .raddr1(rj), .raddr2(rkd), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
    .we(wb_we), .waddr(wb_addr), .wdata(wb_data)
  );

  operand_forward fwd_inst (
    .ctrl(ctrl), .rj(rj), .rkd(rkd), .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
    .es(es_fwd), .ms(ms_fwd), .wb(wb_fwd),
    .rj_value(rj_value), .rkd_value(rkd_value), .stall(stall)
  );

  branch_unit br_inst (
    .ctrl(ctrl), .slot_valid(slot_valid), .pc(ds_pc), .imm(imm),
    .rj_value(rj_value), .rkd_value(rkd_value),
    .br_taken(br_taken), .br_target(br_target)
  );

  assign alu_op      = ctrl.alu_op;
  assign src1_is_pc  = ctrl.src1_is_pc;
  assign src2_is_imm = ctrl.src2_is_imm;
  assign src2_is_4   = ctrl.src2_is_4;
  assign load        = ctrl.load;
  assign store       = ctrl.store;
  assign gr_we       = ctrl.gr_we;
  assign dest        = ctrl.dest;

endmodule

`default_nettype wire

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int TIMEOUT = 50;

  logic      clk, rst, fs_valid, es_allowin;
  word_t     fs_pc, fs_inst;
  logic      es_fwd_stall, es_fwd_en, ms_fwd_stall, ms_fwd_en, wb_we;
  reg_addr_t es_fwd_reg, ms_fwd_reg, wb_addr;
  word_t     es_fwd_data, ms_fwd_data, wb_data;
  logic      ds_allowin, ds_to_es_valid, src1_is_pc, src2_is_imm, src2_is_4;
  logic      load, store, gr_we, br_taken;
  alu_op_t   alu_op;
  reg_addr_t dest;
  word_t     ds_pc, imm, rj_value, rkd_value, br_target;

  integer seed;
  int     errors, checks, tests, test_errs;
  // expected register file contents
  word_t  rv [32];

  id_stage id_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else begin
      $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%-14s %s, %0d errors", name, (errors == test_errs) ? "passed" : "failed",
             errors - test_errs);
    test_errs = errors;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("Test FAILED");
    $finish;
  endtask

  // instruction formats
  function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rk,
                                   input reg_addr_t rj, input reg_addr_t rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic word_t enc_ri12(input logic [9:0] op, input logic [11:0] i12,
                                     input reg_addr_t rj, input reg_addr_t rd);
    return {op, i12, rj, rd};
  endfunction

  function automatic word_t enc_ri16(input logic [5:0] op, input logic [15:0] i16,
                                     input reg_addr_t rj, input reg_addr_t rd);
    return {op, i16, rj, rd};
  endfunction

  function automatic word_t enc_ri20(input logic [6:0] op, input logic [19:0] i20,
                                     input reg_addr_t rd);
    return {op, i20, rd};
  endfunction

  function automatic reg_addr_t rand_reg();
    reg_addr_t r;
    r = $random(seed);
    return (r == '0) ? 5'd13 : r;
  endfunction

  task automatic write_reg(input reg_addr_t a, input word_t d);
    @(posedge clk);
    wb_we   <= 1'b1;
    wb_addr <= a;
    wb_data <= d;
    @(posedge clk);
    wb_we <= 1'b0;
    if (a != '0) rv[a] = d;
  endtask

  // returns at the falling edge after the slot took the instruction
  task automatic send_inst(input word_t pc, input word_t inst, input logic hold,
                           input logic keep);
    int n;
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_pc    <= pc;
    fs_inst  <= inst;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ds_allowin && n < TIMEOUT);
    if (!ds_allowin) abort_run("decode slot never accepted an instruction");
    @(posedge clk);
    fs_valid <= keep;
    if (hold) es_allowin <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ds_to_es_valid && n < TIMEOUT);
    if (!ds_to_es_valid) abort_run("ds_to_es_valid never rose after the stall");
  endtask

  initial begin : main_seq
    reg_addr_t   a, b, d;
    word_t       pc, fe, fm, fw;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [4:0]  ui5;
    logic [16:0] ops [8];
    alu_op_t     alu_exp [8];

    seed = 32'hdd20_2abe;
    errors = 0;
    checks = 0;
    tests = 0;
    test_errs = 0;
    for (int i = 0; i < 32; i++) rv[i] = '0;
    ops = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h29, 17'h2a, 17'h28, 17'h2b};
    alu_exp = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_NOR, ALU_XOR};
    rst = 1'b1;
    fs_valid = 1'b0;
    fs_pc = '0;
    fs_inst = '0;
    es_allowin = 1'b1;
    es_fwd_stall = 1'b0;
    es_fwd_en = 1'b0;
    es_fwd_reg = '0;
    es_fwd_data = '0;
    ms_fwd_stall = 1'b0;
    ms_fwd_en = 1'b0;
    ms_fwd_reg = '0;
    ms_fwd_data = '0;
    wb_we = 1'b0;
    wb_addr = '0;
    wb_data = '0;

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("ds_to_es_valid", ds_to_es_valid, 0);
    check("br_taken", br_taken, 0);
    check("ds_allowin", ds_allowin, 1);
    finish_test("reset");

    for (int i = 1; i < 32; i++) write_reg(5'(i), $random(seed));
    write_reg(5'd0, 32'hdead_beef);
    // first op reads r0 through rj
    for (int i = 0; i < 8; i++) begin
      a = (i == 0) ? 5'd0 : rand_reg();
      b = rand_reg();
      d = rand_reg();
      pc = $random(seed) & ~32'h3;
      send_inst(pc, enc_3r(ops[i], b, a, d), 1'b0, 1'b0);
      check("rj_value", rj_value, rv[a]);
      check("rkd_value", rkd_value, rv[b]);
      check("alu_op", alu_op, alu_exp[i]);
      check("dest", dest, d);
      check("gr_we", gr_we, 1);
      check("ds_pc", ds_pc, pc);
      check("src1_is_pc", src1_is_pc, 0);
      check("src2_is_imm", src2_is_imm, 0);
      check("src2_is_4", src2_is_4, 0);
    end
    send_inst(32'h100, 32'hffff_ffff, 1'b0, 1'b0);
    check("gr_we", gr_we, 0);
    check("load", load, 0);
    check("store", store, 0);
    check("br_taken", br_taken, 0);
    check("alu_op", alu_op, ALU_ADD);
    finish_test("reg_reg");

    a = rand_reg();
    d = rand_reg();
    b = rand_reg();
    i12 = $random(seed) | 12'h800;
    send_inst(32'h200, enc_ri12(10'h00a, i12, a, d), 1'b0, 1'b0);
    check("imm", imm, {{20{i12[11]}}, i12});
    check("src2_is_imm", src2_is_imm, 1);
    check("rj_value", rj_value, rv[a]);
    check("gr_we", gr_we, 1);
    send_inst(32'h204, enc_ri12(10'h00d, i12, a, d), 1'b0, 1'b0);
    check("imm", imm, {20'b0, i12});
    check("alu_op", alu_op, ALU_AND);
    i20 = $random(seed);
    send_inst(32'h208, enc_ri20(7'h0a, i20, d), 1'b0, 1'b0);
    check("imm", imm, {i20, 12'b0});
    check("alu_op", alu_op, ALU_LUI);
    ui5 = $random(seed);
    send_inst(32'h20c, enc_3r(17'h81, ui5, a, d), 1'b0, 1'b0);
    check("imm", imm, {27'b0, ui5});
    check("alu_op", alu_op, ALU_SLL);
    send_inst(32'h210, enc_ri12(10'h0a6, i12, a, b), 1'b0, 1'b0);
    check("rkd_value", rkd_value, rv[b]);
    check("gr_we", gr_we, 0);
    check("store", store, 1);
    check("imm", imm, {{20{i12[11]}}, i12});
    send_inst(32'h214, enc_ri12(10'h0a2, i12, a, d), 1'b0, 1'b0);
    check("load", load, 1);
    check("gr_we", gr_we, 1);
    check("dest", dest, d);
    finish_test("immediates");

    a = rand_reg();
    b = a ^ 5'h10;
    fe = $random(seed);
    fm = $random(seed);
    fw = $random(seed);
    @(posedge clk);
    es_fwd_en <= 1'b1;
    es_fwd_reg <= a;
    es_fwd_data <= fe;
    ms_fwd_en <= 1'b1;
    ms_fwd_reg <= a;
    ms_fwd_data <= fm;
    wb_we <= 1'b1;
    wb_addr <= a;
    wb_data <= fw;
    rv[a] = fw;
    send_inst(32'h300, enc_3r(17'h20, b, a, a), 1'b1, 1'b0);
    check("rj_value", rj_value, fe);
    check("rkd_value", rkd_value, rv[b]);
    @(posedge clk);
    es_fwd_en <= 1'b0;
    @(negedge clk);
    check("rj_value", rj_value, fm);
    // new write-back value that the register file does not hold yet
    fw = ~fw;
    @(posedge clk);
    ms_fwd_en <= 1'b0;
    wb_data <= fw;
    rv[a] = fw;
    @(negedge clk);
    check("rj_value", rj_value, fw);
    @(posedge clk);
    wb_we <= 1'b0;
    @(negedge clk);
    check("rj_value", rj_value, rv[a]);
    @(posedge clk);
    es_allowin <= 1'b1;
    // the held add leaves before the stall starts
    @(posedge clk);
    es_fwd_en <= 1'b1;
    es_fwd_stall <= 1'b1;
    send_inst(32'h304, enc_3r(17'h20, b, a, a), 1'b0, 1'b0);
    repeat (3) begin
      check("ds_to_es_valid", ds_to_es_valid, 0);
      check("ds_allowin", ds_allowin, 0);
      @(negedge clk);
    end
    @(posedge clk);
    es_fwd_stall <= 1'b0;
    es_fwd_en <= 1'b0;
    wait_out_valid();
    check("ds_allowin", ds_allowin, 1);
    finish_test("forwarding");

    a = rand_reg();
    d = rand_reg();
    pc = $random(seed) & ~32'h3;
    i16 = $random(seed);
    // fetch keeps offering the branch but the flush must still win
    send_inst(pc, enc_ri16(6'h16, i16, a, a), 1'b0, 1'b1);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, pc + {{14{i16[15]}}, i16, 2'b0});
    check("ds_to_es_valid", ds_to_es_valid, 1);
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
    check("ds_to_es_valid", ds_to_es_valid, 0);
    check("br_taken", br_taken, 0);
    send_inst(pc, enc_ri16(6'h17, i16, a, a), 1'b0, 1'b0);
    check("br_taken", br_taken, 0);
    send_inst(pc, enc_ri16(6'h13, i16, a, d), 1'b0, 1'b0);
    check("br_taken", br_taken, 1);
    check("br_target", br_target, rv[a] + {{14{i16[15]}}, i16, 2'b0});
    check("gr_we", gr_we, 1);
    check("dest", dest, d);
    check("src1_is_pc", src1_is_pc, 1);
    check("src2_is_4", src2_is_4, 1);
    b = a ^ 5'h10;
    write_reg(a, $random(seed) | 32'h8000_0000);
    write_reg(b, $random(seed) & 32'h7fff_ffff);
    send_inst(pc, enc_ri16(6'h18, i16, a, b), 1'b0, 1'b0);
    check("br_taken", br_taken, 1);
    send_inst(pc, enc_ri16(6'h1a, i16, a, b), 1'b0, 1'b0);
    check("br_taken", br_taken, 0);
    finish_test("branches");

    a = rand_reg();
    b = rand_reg();
    d = rand_reg();
    pc = $random(seed) & ~32'h3;
    send_inst(pc, enc_3r(17'h2b, b, a, d), 1'b1, 1'b0);
    check("ds_allowin", ds_allowin, 0);
    check("ds_to_es_valid", ds_to_es_valid, 1);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_inst <= 32'hffff_ffff;
    fs_pc <= pc + 32'd8;
    repeat (3) begin
      @(negedge clk);
      check("ds_allowin", ds_allowin, 0);
      check("rj_value", rj_value, rv[a]);
      check("rkd_value", rkd_value, rv[b]);
      check("ds_pc", ds_pc, pc);
      check("alu_op", alu_op, ALU_XOR);
      check("dest", dest, d);
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    fs_valid <= 1'b0;
    @(negedge clk);
    check("ds_allowin", ds_allowin, 1);
    check("ds_to_es_valid", ds_to_es_valid, 1);
    @(negedge clk);
    check("ds_to_es_valid", ds_to_es_valid, 0);
    finish_test("backpressure");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/id_pkg.sv
hw/fwd_if.sv
hw/id_slot_ctrl.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/id_stage.sv
testbench/tb_id_stage.sv
